//--- perf_pkg.sv
// --------------------------------------------------------------------------
// Performance monitor package
// Counter sizes, register map constants and the vector types shared by the
// counter bank, the register read port and the testbench
// --------------------------------------------------------------------------
package perf_pkg;

	// Counter bank dimensions
	localparam int NUM_EVENT_COUNTERS = 8;
	localparam int NUM_STRANDS = 4;
	// Dependency wait, data cache wait and instruction cache wait
	localparam int NUM_WAIT_COUNTERS = 3;
	localparam int TOTAL_COUNTERS = NUM_EVENT_COUNTERS + NUM_WAIT_COUNTERS;
	localparam int COUNTER_WIDTH = 48;

	// Enough bits to hold the number of strands waiting in one cycle
	localparam int STRAND_COUNT_WIDTH = $clog2(NUM_STRANDS + 1);

	// Register map
	localparam int BUS_WIDTH = 32;
	localparam int ADDR_WIDTH = 6;
	localparam int INDEX_WIDTH = 4;
	// Upper part of a counter that is returned through the high word
	localparam int SNAPSHOT_WIDTH = COUNTER_WIDTH - BUS_WIDTH;
	// Two words per counter, so the first unmapped address is 22
	localparam int NUM_REG_WORDS = 2 * TOTAL_COUNTERS;

	// Full value of one counter
	typedef logic [COUNTER_WIDTH - 1:0] counter_t;

	// Read data on the register port
	typedef logic [BUS_WIDTH - 1:0] bus_word_t;

	// Word address where counter n sits at words 2n (low) and 2n+1 (high)
	typedef logic [ADDR_WIDTH - 1:0] reg_addr_t;

	// Selects one counter in the bank
	typedef logic [INDEX_WIDTH - 1:0] counter_index_t;

	// One pulse per event counter
	typedef logic [NUM_EVENT_COUNTERS - 1:0] event_vec_t;

	// One wait flag per strand
	typedef logic [NUM_STRANDS - 1:0] strand_mask_t;

endpackage

//--- performance_counters.sv
// --------------------------------------------------------------------------
// Performance counter bank
// Eight single-bit event counters and three strand-wait counters, 48 bits
// each, with a synchronous clear and a combinational counter select
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module performance_counters
	import perf_pkg::*;
(
	input  logic           clk,
	input  logic           reset,
	input  logic           clear,
	input  event_vec_t     events,
	input  strand_mask_t   raw_wait,
	input  strand_mask_t   dcache_wait,
	input  strand_mask_t   icache_wait,
	input  counter_index_t counter_sel,
	output counter_t       counter_value
);

	// Running totals, one entry per counter
	counter_t event_count [NUM_EVENT_COUNTERS];
	counter_t wait_count [NUM_WAIT_COUNTERS];

	// The three wait masks gathered so one loop can handle every category
	strand_mask_t wait_mask [NUM_WAIT_COUNTERS];

	// Number of strands waiting this cycle, per category
	logic [STRAND_COUNT_WIDTH - 1:0] wait_incr [NUM_WAIT_COUNTERS];

	// Index into the wait counter array once the event range is removed
	logic [$clog2(NUM_WAIT_COUNTERS) - 1:0] wait_sel;

	// Population count of a strand mask
	function automatic logic [STRAND_COUNT_WIDTH - 1:0] count_strands(
		input strand_mask_t mask
	);
		logic [STRAND_COUNT_WIDTH - 1:0] total;
		total = '0;
		for (int i = 0; i < NUM_STRANDS; i++)
		begin
			total = total + STRAND_COUNT_WIDTH'(mask[i]);
		end
		return total;
	endfunction

	// Order matches the counter indices 8, 9 and 10
	assign wait_mask[0] = raw_wait;
	assign wait_mask[1] = dcache_wait;
	assign wait_mask[2] = icache_wait;

	always_comb
	begin
		for (int j = 0; j < NUM_WAIT_COUNTERS; j++)
		begin
			wait_incr[j] = count_strands(wait_mask[j]);
		end
	end

	// A clear wins over the increments sampled on the same edge, so the
	// counters read zero afterwards and count from there
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
		begin
			for (int i = 0; i < NUM_EVENT_COUNTERS; i++)
				event_count[i] <= '0;
			for (int j = 0; j < NUM_WAIT_COUNTERS; j++)
				wait_count[j] <= '0;
		end
		else if (clear)
		begin
			for (int i = 0; i < NUM_EVENT_COUNTERS; i++)
				event_count[i] <= '0;
			for (int j = 0; j < NUM_WAIT_COUNTERS; j++)
				wait_count[j] <= '0;
		end
		else
		begin
			// Each event bit adds at most one per cycle
			for (int i = 0; i < NUM_EVENT_COUNTERS; i++)
				event_count[i] <= event_count[i] + counter_t'(events[i]);
			// Several strands waiting at once add several counts
			for (int j = 0; j < NUM_WAIT_COUNTERS; j++)
				wait_count[j] <= wait_count[j] + counter_t'(wait_incr[j]);
		end
	end

	assign wait_sel = $bits(wait_sel)'(counter_sel - counter_index_t'(NUM_EVENT_COUNTERS));

	// Event counters come first and the wait counters follow. Anything past
	// the end of the bank reads as zero
	always_comb
	begin
		if (counter_sel < counter_index_t'(NUM_EVENT_COUNTERS))
			counter_value = event_count[counter_sel[$clog2(NUM_EVENT_COUNTERS) - 1:0]];
		else if (counter_sel < counter_index_t'(TOTAL_COUNTERS))
			counter_value = wait_count[wait_sel];
		else
			counter_value = '0;
	end

endmodule

//--- perf_readout.sv
// --------------------------------------------------------------------------
// Performance counter read port
// Maps 32-bit word addresses onto the counter bank and holds a snapshot of
// the upper bits on every low-word read for a coherent high-word read
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module perf_readout
	import perf_pkg::*;
(
	input  logic           clk,
	input  logic           reset,
	input  logic           rd_strobe,
	input  reg_addr_t      rd_addr,
	output logic           rd_valid,
	output bus_word_t      rd_data,
	output counter_index_t counter_sel,
	input  counter_t       counter_value
);

	// Upper bits of the counter seen at the last low-word read
	logic [SNAPSHOT_WIDTH - 1:0] snapshot;

	// Address decode
	logic addr_in_range;
	logic high_half;

	// Bit 0 picks the half and the rest of the address is the counter index.
	// Addresses past the map may alias a real counter here, but the range
	// check below zeroes their data
	assign counter_sel = INDEX_WIDTH'(rd_addr[ADDR_WIDTH - 1:1]);
	assign high_half = rd_addr[0];
	assign addr_in_range = (rd_addr < reg_addr_t'(NUM_REG_WORDS));

	// Every strobe is answered exactly one cycle later and nothing can stall it
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			rd_valid <= 1'b0;
		else
			rd_valid <= rd_strobe;
	end

	// Only an in-range low read refreshes the snapshot. A high read leaves it
	// alone, so reading another counter's high word without a low read first
	// returns the older value
	always_ff @(posedge clk or posedge reset)
	begin
		if (reset)
			snapshot <= '0;
		else if (rd_strobe && addr_in_range && !high_half)
			snapshot <= counter_value[COUNTER_WIDTH - 1:BUS_WIDTH];
	end

	// Each strobe loads zero, the snapshot or the live low word into the read data
	always_ff @(posedge clk)
	begin
		if (rd_strobe)
		begin
			if (!addr_in_range)
				rd_data <= '0;
			else if (high_half)
				rd_data <= bus_word_t'(snapshot);
			else
				rd_data <= counter_value[BUS_WIDTH - 1:0];
		end
	end

endmodule

//--- perf_monitor_top.sv
// --------------------------------------------------------------------------
// Performance monitor top level
// Joins the counter bank to the register read port
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module perf_monitor_top
	import perf_pkg::*;
(
	input  logic         clk,
	input  logic         reset,
	input  logic         clear,
	input  event_vec_t   events,
	input  strand_mask_t raw_wait,
	input  strand_mask_t dcache_wait,
	input  strand_mask_t icache_wait,
	input  logic         rd_strobe,
	input  reg_addr_t    rd_addr,
	output logic         rd_valid,
	output bus_word_t    rd_data
);

	// Counter chosen by the read port and its live value
	counter_index_t counter_sel;
	counter_t counter_value;

	// Event and wait inputs land in the counters on the next edge
	performance_counters i_counters (
		.clk           (clk),
		.reset         (reset),
		.clear         (clear),
		.events        (events),
		.raw_wait      (raw_wait),
		.dcache_wait   (dcache_wait),
		.icache_wait   (icache_wait),
		.counter_sel   (counter_sel),
		.counter_value (counter_value)
	);

	// The selected value comes back in the same cycle, so the read port
	// answers one cycle after the strobe
	perf_readout i_readout (
		.clk           (clk),
		.reset         (reset),
		.rd_strobe     (rd_strobe),
		.rd_addr       (rd_addr),
		.rd_valid      (rd_valid),
		.rd_data       (rd_data),
		.counter_sel   (counter_sel),
		.counter_value (counter_value)
	);

endmodule

//--- perf_tb_properties.sv
// --------------------------------------------------------------------------
// Performance monitor assertions
// Checks the one-cycle read response and the clear of the counter bank,
// bound into the top level
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module perf_tb_properties
	import perf_pkg::*;
(
	input logic     clk,
	input logic     reset,
	input logic     clear,
	input logic     rd_strobe,
	input logic     rd_valid,
	input counter_t counter_value
);

	// Every strobe is answered on the very next edge
	assert property (@(posedge clk) disable iff (reset) rd_strobe |=> rd_valid)
		else $error("rd_valid did not follow rd_strobe by one cycle");

	// No response appears unless a strobe came one cycle earlier
	assert property (@(posedge clk) disable iff (reset) rd_valid |-> $past(rd_strobe))
		else $error("rd_valid high without a strobe in the previous cycle");

	// The read port stays quiet during reset
	assert property (@(posedge clk) reset |-> !rd_valid)
		else $error("rd_valid high while reset is asserted");

	// All counters are zero after a clear, so whichever one is selected reads zero
	assert property (@(posedge clk) disable iff (reset) clear |=> (counter_value == '0))
		else $error("selected counter not zero after clear");

endmodule

bind perf_monitor_top perf_tb_properties i_properties (
	.clk           (clk),
	.reset         (reset),
	.clear         (clear),
	.rd_strobe     (rd_strobe),
	.rd_valid      (rd_valid),
	.counter_value (counter_value)
);

//--- perf_tb.sv
// --------------------------------------------------------------------------
// Performance monitor testbench
// Replays the operations of the golden file on the top level and compares
// every read response with the expected data from the same file
// --------------------------------------------------------------------------
`timescale 1ns/1ps

module perf_tb
	import perf_pkg::*;
();

	localparam int RESET_CYCLES = 16;
	localparam int DRIVE_DELAY = 2;
	localparam int READ_TIMEOUT = 10;
	localparam int DRAIN_TIMEOUT = 20;

	logic clk = 1'b0;
	logic reset = 1'b1;
	logic clear = 1'b0;
	event_vec_t events = '0;
	strand_mask_t raw_wait = '0;
	strand_mask_t dcache_wait = '0;
	strand_mask_t icache_wait = '0;
	logic rd_strobe = 1'b0;
	reg_addr_t rd_addr = '0;
	logic rd_valid;
	bus_word_t rd_data;

	// Reads that were issued and still wait for their response
	bus_word_t expected_q [$];
	reg_addr_t addr_q [$];

	int checks_done = 0;
	int mismatch_count = 0;
	int timeout_count = 0;
	int other_errors = 0;
	int wait_cycles = 0;
	logic timed_out = 1'b0;

	perf_monitor_top i_dut (
		.clk         (clk),
		.reset       (reset),
		.clear       (clear),
		.events      (events),
		.raw_wait    (raw_wait),
		.dcache_wait (dcache_wait),
		.icache_wait (icache_wait),
		.rd_strobe   (rd_strobe),
		.rd_addr     (rd_addr),
		.rd_valid    (rd_valid),
		.rd_data     (rd_data)
	);

	initial
	begin
		forever #10 clk = ~clk;
	end

	// Compares one read response with its expected value
	task automatic check_value(input string what, input bus_word_t expected,
		input bus_word_t actual);
		checks_done++;
		if (actual !== expected)
		begin
			mismatch_count++;
			$display("ERR time %0t: %s expected %h, got %h", $time, what, expected, actual);
		end
	endtask

	// Applies one operation for one clock cycle, shortly after the rising edge
	task automatic drive_cycle(input logic [7:0] op, input event_vec_t ev,
		input strand_mask_t raw_m, input strand_mask_t dc_m, input strand_mask_t ic_m,
		input reg_addr_t addr, input bus_word_t expected);
		@(posedge clk);
		#DRIVE_DELAY;
		clear = (op == "C");
		rd_strobe = (op == "R");
		events = ev;
		raw_wait = raw_m;
		dcache_wait = dc_m;
		icache_wait = ic_m;
		rd_addr = addr;
		// The response is matched in issue order by the read monitor
		if (op == "R")
		begin
			expected_q.push_back(expected);
			addr_q.push_back(addr);
		end
	endtask

	// The read monitor samples each response at the falling edge where it is stable
	initial
	begin
		reg_addr_t addr;
		bus_word_t expected;
		while (!timed_out)
		begin
			@(negedge clk);
			if (rd_valid)
			begin
				if (expected_q.size() == 0)
				begin
					other_errors++;
					$display("rd_valid was high at time %0t with no read outstanding", $time);
				end
				else
				begin
					expected = expected_q.pop_front();
					addr = addr_q.pop_front();
					check_value($sformatf("read of word %0d", addr), expected, rd_data);
				end
				wait_cycles = 0;
			end
			else if (expected_q.size() != 0)
			begin
				// Each outstanding read gets its own budget of cycles
				wait_cycles++;
				if (wait_cycles > READ_TIMEOUT)
				begin
					timeout_count++;
					$display("Timeout: no rd_valid within %0d cycles for the read of word %0d",
						READ_TIMEOUT, addr_q[0]);
					timed_out = 1'b1;
				end
			end
		end
	end

	initial
	begin
		int fd;
		int code;
		int drain_cycles;
		logic done;
		logic [7:0] op_char;
		logic [799:0] skip_line;
		event_vec_t ev;
		strand_mask_t raw_m;
		strand_mask_t dc_m;
		strand_mask_t ic_m;
		reg_addr_t addr;
		bus_word_t expected;
		fd = $fopen("perf_golden.txt", "r");
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		reset = 1'b0;
		if (fd == 0)
		begin
			other_errors++;
			$display("Could not open the golden file perf_golden.txt");
		end
		else
		begin
			done = 1'b0;
			while (!done && !timed_out)
			begin
				code = $fscanf(fd, " %c", op_char);
				if (code != 1)
					done = 1'b1;
				else if (op_char == "#")
					code = $fgets(skip_line, fd);
				else
				begin
					ev = '0;
					raw_m = '0;
					dc_m = '0;
					ic_m = '0;
					addr = '0;
					expected = '0;
					// A clear line carries events too and the DUT must discard them
					if (op_char == "E" || op_char == "C")
					begin
						code = $fscanf(fd, " %h %h %h %h", ev, raw_m, dc_m, ic_m);
						if (code != 4)
						begin
							other_errors++;
							$display("Golden file line for operation %c is incomplete", op_char);
						end
					end
					else if (op_char == "R")
					begin
						code = $fscanf(fd, " %h %h", addr, expected);
						if (code != 2)
						begin
							other_errors++;
							$display("Golden file read line is incomplete");
						end
					end
					else if (op_char != "I")
					begin
						other_errors++;
						$display("Unknown operation %c in the golden file", op_char);
					end
					drive_cycle(op_char, ev, raw_m, dc_m, ic_m, addr, expected);
				end
			end
			$fclose(fd);
		end
		// Return all inputs to idle and let the last responses arrive
		drive_cycle("I", '0, '0, '0, '0, '0, '0);
		drain_cycles = 0;
		while (expected_q.size() != 0 && !timed_out && drain_cycles < DRAIN_TIMEOUT)
		begin
			@(negedge clk);
			drain_cycles++;
		end
		if (expected_q.size() != 0 && !timed_out)
		begin
			timeout_count++;
			$display("Timeout: %0d reads still had no response after the stimulus ended",
				expected_q.size());
		end
		$display("Reads checked %0d, mismatches %0d, timeouts %0d, other errors %0d",
			checks_done, mismatch_count, timeout_count, other_errors);
		if (checks_done > 0 && mismatch_count == 0 && timeout_count == 0 && other_errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

endmodule

//--- perf_golden.txt
# E and C: events raw_wait dcache_wait icache_wait in hex, C also clears
# R: word address and expected read data in hex, I: one idle cycle
E 01 1 0 0
E 03 3 1 0
E 87 7 3 8
E ff f 7 c
E 80 0 f f
I
R 00 4
R 02 3
R 04 2
R 06 1
R 08 1
R 0a 1
R 0c 1
R 0e 3
R 10 a
R 12 a
R 14 7
R 00 4
E ff f f f
R 01 0
R 03 0
R 02 4
R 0e 4
R 16 0
R 20 0
R 3f 0
C ff f f f
R 00 0
R 14 0
E 05 2 0 1
R 00 1
R 02 0
R 10 1

//--- project.f
perf_pkg.sv
performance_counters.sv
perf_readout.sv
perf_monitor_top.sv
perf_tb_properties.sv
perf_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the performance monitor testbench with Verilator, runs it and
# decides pass or fail from the simulation log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --assert --top-module perf_tb -f project.f -o perf_sim
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

./obj_dir/perf_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if grep -q "^Everything OK$" "$LOG"; then
	echo "PASS"
	exit 0
else
	echo "FAIL"
	exit 1
fi
